// File: hdl/special_settings.svh
// Width settings for the special-instruction unit
// Include this before the package or any module that sizes ports with them
`ifndef SPECIAL_SETTINGS_SVH
`define SPECIAL_SETTINGS_SVH

// Instruction-kind code
`define SPECIAL_KIND_W 3

// Retired-instruction counter, wraps on overflow
`define SPECIAL_RETIRE_CNT_W 16

// Low-power state code
`define SPECIAL_LPMD_W 2

`endif

// File: hdl/special_pkg.sv
// Shared types of the special-instruction unit
// Modules refer to these by scoped name, for example special_pkg::WFI
`include "special_settings.svh"
`default_nettype none

package special_pkg;

  // Serialising instructions handed over by the issue stage
  typedef enum logic [`SPECIAL_KIND_W-1:0] {
    FENCE,
    FENCEI,
    SYNC,
    SYNCI,
    WFI
  } special_kind_e;

  // Operation requested from the load/store unit
  typedef enum logic {
    OP_FENCE,
    OP_SYNC
  } lsu_op_e;

  // Low-power sequence as seen from outside
  typedef enum logic [`SPECIAL_LPMD_W-1:0] {
    LPMD_IDLE,
    LPMD_WAIT_SYNC,
    LPMD_SLEEP,
    LPMD_EXIT
  } lpmd_state_e;

endpackage

`default_nettype wire

// File: hdl/special_op_if.sv
// Four-phase link between the decode, execute and result stages
// Decode requests with a held kind, execute acknowledges once the whole
// sequence has finished and pulses done, result watches the exchange
`timescale 1ns/1ps
`default_nettype none

interface special_op_if;

  // Request from decode, held until ack is seen
  logic                       req;
  // Acknowledge from execute, held until req falls
  logic                       ack;
  // Kind of the instruction in flight
  special_pkg::special_kind_e kind;
  // One-cycle completion pulse, coincides with the rise of ack
  logic                       done;

  modport decode (
    output req,
    output kind,
    input  ack
  );

  modport execute (
    input  req,
    input  kind,
    output ack,
    output done
  );

  modport result (
    input  req,
    input  kind,
    input  done
  );

endinterface

`default_nettype wire

// File: hdl/special_decode.sv
// Decode stage of the special-instruction unit
// Captures the instruction kind from the issue stage and runs the requesting
// side of the four-phase link to the execute stage
`timescale 1ns/1ps
`default_nettype none

module special_decode (
  input  logic                       special_clk,
  input  logic                       cpurst_b,
  input  logic                       iui_vld,
  input  special_pkg::special_kind_e iui_kind,
  input  logic                       iui_stall,
  special_op_if.decode               op
);

  typedef enum logic [1:0] {
    DEC_IDLE,
    DEC_REQ,
    DEC_RELEASE
  } dec_state_e;

  dec_state_e                 dec_state;
  logic                       pend;
  logic                       accept;
  special_pkg::special_kind_e kind_q;

  // Valid only counts while the unit is not stalled
  assign accept = iui_vld && !iui_stall;

  // Kind is held until the next accepted instruction
  always_ff @(posedge special_clk)
  begin
    if (accept)
      kind_q <= iui_kind;
  end

  //========================================
  // Request side of the handshake
  //========================================
  always_ff @(posedge special_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      dec_state <= DEC_IDLE;
      pend      <= 1'b0;
    end
    else
    begin
      case (dec_state)
        DEC_IDLE:
          if (pend)
          begin
            dec_state <= DEC_REQ;
            pend      <= 1'b0;
          end
        DEC_REQ:
          if (op.ack)
            dec_state <= DEC_RELEASE;
        DEC_RELEASE:
          // Back-to-back instruction may go straight out once ack is low
          if (!op.ack)
          begin
            dec_state <= pend ? DEC_REQ : DEC_IDLE;
            pend      <= 1'b0;
          end
        default:
          dec_state <= DEC_IDLE;
      endcase
      if (accept)
        pend <= 1'b1;
    end
  end

  assign op.req  = (dec_state == DEC_REQ);
  assign op.kind = kind_q;

endmodule

`default_nettype wire

// File: hdl/special_fence_seq.sv
// Execute stage of the special-instruction unit
// Walks the fixed transaction sequence for the held kind: a fence or sync
// request to the load/store unit, an optional instruction-cache invalidate
// to the fetch unit, and for wfi the low-power states until wake-up.
// Completion raises ack on the internal link with a one-cycle done pulse.
`timescale 1ns/1ps
`default_nettype none

module special_fence_seq (
  input  logic                     special_clk,
  input  logic                     cpurst_b,
  special_op_if.execute            op,
  output logic                     lsu_req,
  output special_pkg::lsu_op_e     lsu_op,
  input  logic                     lsu_ack,
  output logic                     ifu_inv_req,
  input  logic                     ifu_inv_ack,
  input  logic                     wake_up,
  output special_pkg::lpmd_state_e lpmd_state,
  output logic                     in_lpmd
);

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_LSU_REQ,
    SEQ_LSU_REL,
    SEQ_IFU_REQ,
    SEQ_IFU_REL,
    SEQ_SLEEP,
    SEQ_EXIT,
    SEQ_ACK
  } seq_state_e;

  seq_state_e seq_state;
  logic       ack_q;
  logic       done_q;
  logic       start;
  logic       need_inv;
  logic       is_wfi;
  logic       is_fence;

  //========================================
  // Kind decoding
  //========================================
  assign need_inv = (op.kind == special_pkg::FENCEI) || (op.kind == special_pkg::SYNCI);
  assign is_wfi   = (op.kind == special_pkg::WFI);
  assign is_fence = (op.kind == special_pkg::FENCE) || (op.kind == special_pkg::FENCEI);

  // New request on the link while our ack is already low
  assign start = (seq_state == SEQ_IDLE) && op.req && !ack_q;

  // LSU operation is fixed for the whole transaction
  always_ff @(posedge special_clk)
  begin
    if (start)
      lsu_op <= is_fence ? special_pkg::OP_FENCE : special_pkg::OP_SYNC;
  end

  //========================================
  // Sequencer
  //========================================
  always_ff @(posedge special_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      seq_state   <= SEQ_IDLE;
      lsu_req     <= 1'b0;
      ifu_inv_req <= 1'b0;
      lpmd_state  <= special_pkg::LPMD_IDLE;
      ack_q       <= 1'b0;
      done_q      <= 1'b0;
    end
    else
    begin
      done_q <= 1'b0;
      case (seq_state)
        SEQ_IDLE:
          if (start)
          begin
            lsu_req   <= 1'b1;
            seq_state <= SEQ_LSU_REQ;
            if (is_wfi)
              lpmd_state <= special_pkg::LPMD_WAIT_SYNC;
          end
        SEQ_LSU_REQ:
          if (lsu_ack)
          begin
            lsu_req   <= 1'b0;
            seq_state <= SEQ_LSU_REL;
          end
        SEQ_LSU_REL:
          // Next step only once the LSU has dropped its ack
          if (!lsu_ack)
          begin
            if (need_inv)
            begin
              ifu_inv_req <= 1'b1;
              seq_state   <= SEQ_IFU_REQ;
            end
            else if (is_wfi)
            begin
              lpmd_state <= special_pkg::LPMD_SLEEP;
              seq_state  <= SEQ_SLEEP;
            end
            else
            begin
              ack_q     <= 1'b1;
              done_q    <= 1'b1;
              seq_state <= SEQ_ACK;
            end
          end
        SEQ_IFU_REQ:
          if (ifu_inv_ack)
          begin
            ifu_inv_req <= 1'b0;
            seq_state   <= SEQ_IFU_REL;
          end
        SEQ_IFU_REL:
          if (!ifu_inv_ack)
          begin
            ack_q     <= 1'b1;
            done_q    <= 1'b1;
            seq_state <= SEQ_ACK;
          end
        SEQ_SLEEP:
          if (wake_up)
          begin
            lpmd_state <= special_pkg::LPMD_EXIT;
            seq_state  <= SEQ_EXIT;
          end
        SEQ_EXIT:
          begin
            lpmd_state <= special_pkg::LPMD_IDLE;
            ack_q      <= 1'b1;
            done_q     <= 1'b1;
            seq_state  <= SEQ_ACK;
          end
        SEQ_ACK:
          // Hold ack until decode withdraws its request
          if (!op.req)
          begin
            ack_q     <= 1'b0;
            seq_state <= SEQ_IDLE;
          end
        default:
          seq_state <= SEQ_IDLE;
      endcase
    end
  end

  assign in_lpmd = (lpmd_state == special_pkg::LPMD_SLEEP);
  assign op.ack  = ack_q;
  assign op.done = done_q;

endmodule

`default_nettype wire

// File: hdl/special_retire.sv
// Result stage of the special-instruction unit
// Holds the issue stage stalled from acceptance until completion, registers
// the sync-stall indication for the performance counters and counts
// retired instructions
`include "special_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module special_retire (
  input  logic                             special_clk,
  input  logic                             cpurst_b,
  input  logic                             iui_vld,
  special_op_if.result                     op,
  output logic                             iui_stall,
  output logic                             sync_stall_vld,
  output logic [`SPECIAL_RETIRE_CNT_W-1:0] retire_cnt
);

  logic retire_evt;
  logic not_wfi;

  // Completion that answers the request still on the link
  assign retire_evt = op.done && op.req;
  assign not_wfi    = (op.kind != special_pkg::WFI);

  //========================================
  // Issue stall
  //========================================
  always_ff @(posedge special_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      iui_stall <= 1'b0;
    else if (retire_evt)
      iui_stall <= 1'b0;
    else if (iui_vld && !iui_stall)
      iui_stall <= 1'b1;
  end

  //========================================
  // Performance information
  //========================================
  // wfi time is sleep, not a sync stall
  always_ff @(posedge special_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      sync_stall_vld <= 1'b0;
    else
      sync_stall_vld <= iui_stall && not_wfi;
  end

  always_ff @(posedge special_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      retire_cnt <= '0;
    else if (retire_evt)
      retire_cnt <= retire_cnt + 1'b1;
  end

endmodule

`default_nettype wire

// File: hdl/special_top.sv
// Top level of the special-instruction unit
// Connects decode, execute and result over the internal link and exposes
// the issue, LSU, fetch-unit and low-power handshakes as plain ports
`include "special_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module special_top (
  input  logic                             special_clk,
  input  logic                             cpurst_b,
  // Issue stage
  input  logic                             iui_vld,
  input  special_pkg::special_kind_e       iui_kind,
  output logic                             iui_stall,
  // Load/store unit
  output logic                             lsu_req,
  output special_pkg::lsu_op_e             lsu_op,
  input  logic                             lsu_ack,
  // Fetch unit
  output logic                             ifu_inv_req,
  input  logic                             ifu_inv_ack,
  // Low power
  input  logic                             wake_up,
  output special_pkg::lpmd_state_e         lpmd_state,
  output logic                             in_lpmd,
  // Performance counters
  output logic                             sync_stall_vld,
  output logic [`SPECIAL_RETIRE_CNT_W-1:0] retire_cnt
);

  special_op_if op_if ();

  special_decode u_decode (
    .special_clk (special_clk),
    .cpurst_b    (cpurst_b),
    .iui_vld     (iui_vld),
    .iui_kind    (iui_kind),
    .iui_stall   (iui_stall),
    .op          (op_if.decode)
  );

  special_fence_seq u_fence_seq (
    .special_clk (special_clk),
    .cpurst_b    (cpurst_b),
    .op          (op_if.execute),
    .lsu_req     (lsu_req),
    .lsu_op      (lsu_op),
    .lsu_ack     (lsu_ack),
    .ifu_inv_req (ifu_inv_req),
    .ifu_inv_ack (ifu_inv_ack),
    .wake_up     (wake_up),
    .lpmd_state  (lpmd_state),
    .in_lpmd     (in_lpmd)
  );

  special_retire u_retire (
    .special_clk    (special_clk),
    .cpurst_b       (cpurst_b),
    .iui_vld        (iui_vld),
    .op             (op_if.result),
    .iui_stall      (iui_stall),
    .sync_stall_vld (sync_stall_vld),
    .retire_cnt     (retire_cnt)
  );

endmodule

`default_nettype wire

// File: test/special_properties.sv
// Handshake assertions for the special-instruction unit
// Bound into special_top to watch the LSU, fetch-unit and low-power ports
`timescale 1ns/1ps
`default_nettype none

module special_properties (
  input logic                 special_clk,
  input logic                 cpurst_b,
  input logic                 lsu_req,
  input logic                 lsu_ack,
  input special_pkg::lsu_op_e lsu_op,
  input logic                 ifu_inv_req,
  input logic                 ifu_inv_ack,
  input logic                 in_lpmd
);

  // Number of assertion failures so far
  int assert_fail_cnt = 0;

  // Requests stay up until the responder acknowledges
  lsu_req_held: assert property (@(posedge special_clk) disable iff (!cpurst_b)
    lsu_req && !lsu_ack |=> lsu_req)
    else
    begin
      $error("lsu_req dropped before lsu_ack");
      assert_fail_cnt++;
    end

  inv_req_held: assert property (@(posedge special_clk) disable iff (!cpurst_b)
    ifu_inv_req && !ifu_inv_ack |=> ifu_inv_req)
    else
    begin
      $error("ifu_inv_req dropped before ifu_inv_ack");
      assert_fail_cnt++;
    end

  lsu_op_stable: assert property (@(posedge special_clk) disable iff (!cpurst_b)
    lsu_req && $past(lsu_req) |-> $stable(lsu_op))
    else
    begin
      $error("lsu_op changed during an LSU request");
      assert_fail_cnt++;
    end

  // No memory request while asleep
  lpmd_no_lsu: assert property (@(posedge special_clk) disable iff (!cpurst_b)
    !(in_lpmd && lsu_req))
    else
    begin
      $error("in_lpmd high together with lsu_req");
      assert_fail_cnt++;
    end

endmodule

bind special_top special_properties u_properties (
  .special_clk (special_clk),
  .cpurst_b    (cpurst_b),
  .lsu_req     (lsu_req),
  .lsu_ack     (lsu_ack),
  .lsu_op      (lsu_op),
  .ifu_inv_req (ifu_inv_req),
  .ifu_inv_ack (ifu_inv_ack),
  .in_lpmd     (in_lpmd)
);

`default_nettype wire

// File: test/special_tb.sv
// Testbench for the special-instruction unit
// Issues random serialising instructions at random gaps, answers the LSU,
// fetch-unit and wake-up handshakes with random delays and checks the DUT
// against a transaction model kept in a queue
`include "special_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module special_tb;

  localparam int NUM_INSTR  = 200;
  localparam int MAX_CYCLES = NUM_INSTR * 40;
  // Transaction codes held in the model queue
  localparam int TXN_FENCE  = 0;
  localparam int TXN_SYNC   = 1;
  localparam int TXN_INV    = 2;
  localparam int TXN_SLEEP  = 3;

  logic                             special_clk = 1'b0;
  logic                             cpurst_b;
  logic                             iui_vld;
  special_pkg::special_kind_e       iui_kind;
  logic                             iui_stall;
  logic                             lsu_req;
  special_pkg::lsu_op_e             lsu_op;
  logic                             lsu_ack;
  logic                             ifu_inv_req;
  logic                             ifu_inv_ack;
  logic                             wake_up;
  special_pkg::lpmd_state_e         lpmd_state;
  logic                             in_lpmd;
  logic                             sync_stall_vld;
  logic [`SPECIAL_RETIRE_CNT_W-1:0] retire_cnt;

  int                         exp_q[$];
  int                         accepted_cnt = 0;
  int                         ignored_cnt = 0;
  int                         finished_cnt = 0;
  int                         check_cnt = 0;
  int                         error_cnt = 0;
  int                         cycle_cnt = 0;
  logic                       mon_on = 1'b0;
  logic                       wake_seen = 1'b0;
  logic                       exp_sync_stall = 1'b0;
  logic                       accepted_last = 1'b0;
  logic                       prev_stall = 1'b0;
  logic                       prev_lsu_req = 1'b0;
  logic                       prev_inv_req = 1'b0;
  logic                       prev_lpmd = 1'b0;
  special_pkg::special_kind_e held_kind = special_pkg::FENCE;

  special_top DUT (.*);

  always #50 special_clk = ~special_clk;

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_cnt++;
    if (actual !== expected)
    begin
      error_cnt++;
      $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
    end
  endtask

  // Skip n cycles and stop just after the next rising edge
  task automatic wait_drive_slot(input int unsigned n);
    repeat (n) @(negedge special_clk);
    @(posedge special_clk);
    #1;
  endtask

  // Transactions that one accepted kind must produce in order
  task automatic push_sequence(input special_pkg::special_kind_e kind);
    if (kind == special_pkg::FENCE || kind == special_pkg::FENCEI)
      exp_q.push_back(TXN_FENCE);
    else
      exp_q.push_back(TXN_SYNC);
    if (kind == special_pkg::FENCEI || kind == special_pkg::SYNCI)
      exp_q.push_back(TXN_INV);
    else if (kind == special_pkg::WFI)
      exp_q.push_back(TXN_SLEEP);
  endtask

  task automatic match_txn(input string name, input int code);
    if (exp_q.size() == 0)
    begin
      error_cnt++;
      $display("Unexpected %s transaction with no instruction pending at %0t", name, $time);
    end
    else
      check_value(name, code, exp_q.pop_front());
  endtask

  //========================================
  // Monitor and model on the falling edge
  //========================================
  always @(negedge special_clk)
  begin
    if (mon_on)
    begin
      check_value("sync_stall_vld", sync_stall_vld, exp_sync_stall);
      exp_sync_stall = iui_stall && (held_kind != special_pkg::WFI);
      if (prev_stall && !iui_stall)
      begin
        finished_cnt++;
        if (exp_q.size() != 0)
        begin
          error_cnt++;
          $display("Instruction retired with %0d transactions missing", exp_q.size());
        end
      end
      // Stall must be up right after an accepted instruction
      if (accepted_last)
        check_value("iui_stall", iui_stall, 1);
      if (!iui_stall)
        check_value("retire_cnt", retire_cnt, accepted_cnt);
      accepted_last = iui_vld && !iui_stall;
      if (accepted_last)
      begin
        held_kind = iui_kind;
        push_sequence(iui_kind);
        accepted_cnt++;
      end
      else if (iui_vld)
        ignored_cnt++;
      if (lsu_req && !prev_lsu_req)
        match_txn("lsu_op", (lsu_op == special_pkg::OP_SYNC) ? TXN_SYNC : TXN_FENCE);
      if (ifu_inv_req && !prev_inv_req)
        match_txn("ifu_inv_req", TXN_INV);
      // Sleep only after the sync has fully closed
      if (in_lpmd && !prev_lpmd)
      begin
        match_txn("in_lpmd", TXN_SLEEP);
        check_value("lsu_req", lsu_req, 0);
        check_value("lsu_ack", lsu_ack, 0);
        check_value("lpmd_state", lpmd_state, special_pkg::LPMD_SLEEP);
        wake_seen = 1'b0;
      end
      if (in_lpmd && wake_up)
        wake_seen = 1'b1;
      if (!in_lpmd && prev_lpmd)
      begin
        check_value("wake_up", wake_seen, 1);
        check_value("lpmd_state", lpmd_state, special_pkg::LPMD_EXIT);
      end
      prev_stall   = iui_stall;
      prev_lsu_req = lsu_req;
      prev_inv_req = ifu_inv_req;
      prev_lpmd    = in_lpmd;
    end
  end

  //========================================
  // Responders
  //========================================
  always
  begin : lsu_responder
    @(negedge special_clk);
    if (lsu_req)
    begin
      wait_drive_slot($urandom_range(0, 5));
      lsu_ack = 1'b1;
      while (lsu_req)
        @(negedge special_clk);
      wait_drive_slot($urandom_range(0, 5));
      lsu_ack = 1'b0;
    end
  end

  always
  begin : ifu_responder
    @(negedge special_clk);
    if (ifu_inv_req)
    begin
      wait_drive_slot($urandom_range(0, 5));
      ifu_inv_ack = 1'b1;
      while (ifu_inv_req)
        @(negedge special_clk);
      wait_drive_slot($urandom_range(0, 5));
      ifu_inv_ack = 1'b0;
    end
  end

  // One-cycle wake-up pulse some time into the sleep
  always
  begin : wake_source
    @(negedge special_clk);
    if (in_lpmd)
    begin
      wait_drive_slot($urandom_range(0, 7));
      wake_up = 1'b1;
      wait_drive_slot(0);
      wake_up = 1'b0;
      while (in_lpmd)
        @(negedge special_clk);
    end
  end

  always @(posedge special_clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES)
    begin
      $display("Timeout after %0d cycles with %0d of %0d instructions retired",
               cycle_cnt, finished_cnt, NUM_INSTR);
      $display(">>> FAIL");
      $finish;
    end
  end

  //========================================
  // Main sequence
  //========================================
  initial
  begin
    void'($urandom(32'h7c5819de));
    cpurst_b    = 1'b0;
    iui_vld     = 1'b0;
    iui_kind    = special_pkg::FENCE;
    lsu_ack     = 1'b0;
    ifu_inv_ack = 1'b0;
    wake_up     = 1'b0;
    repeat (10) @(posedge special_clk);
    #1;
    cpurst_b = 1'b1;
    mon_on   = 1'b1;
    @(negedge special_clk);
    check_value("iui_stall", iui_stall, 0);
    check_value("lsu_req", lsu_req, 0);
    check_value("ifu_inv_req", ifu_inv_req, 0);
    check_value("in_lpmd", in_lpmd, 0);
    check_value("sync_stall_vld", sync_stall_vld, 0);
    check_value("retire_cnt", retire_cnt, 0);
    check_value("lpmd_state", lpmd_state, special_pkg::LPMD_IDLE);
    // Attempts during a stall are issued too and must be ignored
    while (accepted_cnt < NUM_INSTR)
    begin
      wait_drive_slot($urandom_range(0, 6));
      iui_vld  = 1'b1;
      iui_kind = special_pkg::special_kind_e'($urandom_range(0, 4));
      wait_drive_slot(0);
      iui_vld  = 1'b0;
    end
    while (finished_cnt < NUM_INSTR)
      @(negedge special_clk);
    repeat (4) @(negedge special_clk);
    $display("Accepted %0d, ignored %0d, checks %0d, errors %0d, assertion failures %0d",
             accepted_cnt, ignored_cnt, check_cnt, error_cnt,
             DUT.u_properties.assert_fail_cnt);
    if (error_cnt == 0 && DUT.u_properties.assert_fail_cnt == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hdl
hdl/special_pkg.sv
hdl/special_op_if.sv
hdl/special_decode.sv
hdl/special_fence_seq.sv
hdl/special_retire.sv
hdl/special_top.sv
test/special_properties.sv
test/special_tb.sv

// File: Bender.yml
package:
  name: special_unit

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/special_pkg.sv
      - hdl/special_op_if.sv
      - hdl/special_decode.sv
      - hdl/special_fence_seq.sv
      - hdl/special_retire.sv
      - hdl/special_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/special_properties.sv
      - test/special_tb.sv
